// ==== common/axi_mem_pkg.sv ====
package axi_mem_pkg;

	// data bits covered by one write strobe bit
	localparam int BYTE_W = 8;

	// response codes on the r and b channels
	// only the two this slave can produce
	typedef enum logic [1:0] {
		RESP_OKAY   = 2'b00,
		RESP_SLVERR = 2'b10
	} resp_t;

	// slave controller states
	// one transaction in flight, so the response state also says which
	// channel currently owns the slave
	typedef enum logic [1:0] {
		ST_IDLE       = 2'b00, // readies up, waiting for a request
		ST_READ_RESP  = 2'b01, // read data held on r channel
		ST_WRITE_RESP = 2'b10  // write response held on b channel
	} ctrl_state_t;

endpackage

// ==== axi_sram/sram_array.sv ====
`timescale 1ns/1ps

module sram_array
	import axi_mem_pkg::*;
#(
	parameter int DATA_W     = 32,
	parameter int DEPTH_LOG2 = 8
) (
	input  logic                     clk,
	input  logic                     mem_en_i,
	input  logic                     mem_we_i,
	input  logic [DEPTH_LOG2-1:0]    mem_idx_i,
	input  logic [DATA_W/BYTE_W-1:0] mem_be_i,
	input  logic [DATA_W-1:0]        mem_wdata_i,
	output logic [DATA_W-1:0]        mem_rdata_o
);

	localparam int LANES = DATA_W / BYTE_W;
	localparam int WORDS = 1 << DEPTH_LOG2;

	logic [DATA_W-1:0] mem [WORDS];
	logic [DATA_W-1:0] rdata_q; // last word read

	// byte lanes with a clear enable keep their old contents
	always_ff @(posedge clk) begin
		if (mem_en_i && mem_we_i) begin
			for (int i = 0; i < LANES; i++) begin
				if (mem_be_i[i]) begin
					mem[mem_idx_i][i*BYTE_W +: BYTE_W] <= mem_wdata_i[i*BYTE_W +: BYTE_W];
				end
			end
		end
	end

	// registered read
	// the word stays put until the next enabled read, so the r channel
	// can sit on it for as long as the master stalls
	always_ff @(posedge clk) begin
		if (mem_en_i && !mem_we_i) begin
			rdata_q <= mem[mem_idx_i];
		end
	end

	assign mem_rdata_o = rdata_q;

endmodule

// ==== axi_sram/axi_sram_ctrl.sv ====
`timescale 1ns/1ps

module axi_sram_ctrl
	import axi_mem_pkg::*;
#(
	parameter int ADDR_W     = 32,
	parameter int DATA_W     = 32, // multiple of BYTE_W
	parameter int DEPTH_LOG2 = 8
) (
	input  logic                     clk,
	input  logic                     rst,

	// read address
	input  logic [ADDR_W-1:0]        ar_addr_i,
	input  logic                     ar_valid_i,
	output logic                     ar_ready_o,

	// read data
	output logic [DATA_W-1:0]        r_data_o,
	output resp_t                    r_resp_o,
	output logic                     r_valid_o,
	input  logic                     r_ready_i,

	// write address
	input  logic [ADDR_W-1:0]        aw_addr_i,
	input  logic                     aw_valid_i,
	output logic                     aw_ready_o,

	// write data
	input  logic [DATA_W-1:0]        w_data_i,
	input  logic [DATA_W/BYTE_W-1:0] w_strb_i,
	input  logic                     w_valid_i,
	output logic                     w_ready_o,

	// write response
	output resp_t                    b_resp_o,
	output logic                     b_valid_o,
	input  logic                     b_ready_i
);

	localparam int LANES  = DATA_W / BYTE_W;
	localparam int OFFS_W = $clog2(LANES);       // byte offset bits inside a word
	localparam int IDX_HI = OFFS_W + DEPTH_LOG2; // first address bit above the index

	ctrl_state_t state_q;
	ctrl_state_t state_d;
	logic live_q; // high from the second cycle after reset

	logic idle_rdy;
	logic rd_fire;
	logic wr_fire;

	logic [ADDR_W-1:0]     req_addr;
	logic [DEPTH_LOG2-1:0] req_idx;
	logic                  req_oob;
	logic                  err_q; // range result of the accepted request

	logic              mem_en;
	logic              mem_we;
	logic [DATA_W-1:0] mem_rdata;

	// one cycle of extra quiet after reset before taking requests
	always_ff @(posedge clk) begin
		if (rst) begin
			live_q <= 1'b0;
		end else begin
			live_q <= 1'b1;
		end
	end

	// all three input readies share one condition
	assign idle_rdy   = live_q && (state_q == ST_IDLE);
	assign ar_ready_o = idle_rdy;
	assign aw_ready_o = idle_rdy;
	assign w_ready_o  = idle_rdy;

	// read wins a same-cycle contest
	// a write needs address and data together
	assign rd_fire = idle_rdy && ar_valid_i;
	assign wr_fire = idle_rdy && aw_valid_i && w_valid_i && !ar_valid_i;

	// decode from whichever address won
	assign req_addr = rd_fire ? ar_addr_i : aw_addr_i;
	assign req_idx  = req_addr[IDX_HI-1:OFFS_W];
	assign req_oob  = |req_addr[ADDR_W-1:IDX_HI];

	// an out-of-range write never reaches the array
	assign mem_en = rd_fire || (wr_fire && !req_oob);
	assign mem_we = wr_fire;

	always_comb begin
		state_d = state_q;
		unique case (state_q)
			ST_IDLE: begin
				if (rd_fire) begin
					state_d = ST_READ_RESP;
				end else if (wr_fire) begin
					state_d = ST_WRITE_RESP;
				end
			end
			ST_READ_RESP: begin
				if (r_ready_i) begin
					state_d = ST_IDLE;
				end
			end
			ST_WRITE_RESP: begin
				if (b_ready_i) begin
					state_d = ST_IDLE;
				end
			end
			default: begin
				state_d = ST_IDLE;
			end
		endcase
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			state_q <= ST_IDLE;
		end else begin
			state_q <= state_d;
		end
	end

	// range result captured at the accepting edge
	always_ff @(posedge clk) begin
		if (rd_fire || wr_fire) begin
			err_q <= req_oob;
		end
	end

	// response channels, stable while the state holds
	assign r_valid_o = (state_q == ST_READ_RESP);
	assign b_valid_o = (state_q == ST_WRITE_RESP);

	assign r_resp_o = (r_valid_o && err_q) ? RESP_SLVERR : RESP_OKAY;
	assign b_resp_o = (b_valid_o && err_q) ? RESP_SLVERR : RESP_OKAY;
	assign r_data_o = err_q ? '0 : mem_rdata; // zero on a bad read

	sram_array #(
		.DATA_W     (DATA_W),
		.DEPTH_LOG2 (DEPTH_LOG2)
	) u_sram_array (
		.clk         (clk),
		.mem_en_i    (mem_en),
		.mem_we_i    (mem_we),
		.mem_idx_i   (req_idx),
		.mem_be_i    (w_strb_i),
		.mem_wdata_i (w_data_i),
		.mem_rdata_o (mem_rdata)
	);

endmodule

// ==== verilog/axi_mem_top.sv ====
`timescale 1ns/1ps

module axi_mem_top
	import axi_mem_pkg::*;
#(
	parameter int ADDR_W     = 32,
	parameter int DATA_W     = 32,
	parameter int DEPTH_LOG2 = 8   // 256 words
) (
	input  logic                     clk,
	input  logic                     rst,

	input  logic [ADDR_W-1:0]        ar_addr_i,
	input  logic                     ar_valid_i,
	output logic                     ar_ready_o,

	output logic [DATA_W-1:0]        r_data_o,
	output resp_t                    r_resp_o,
	output logic                     r_valid_o,
	input  logic                     r_ready_i,

	input  logic [ADDR_W-1:0]        aw_addr_i,
	input  logic                     aw_valid_i,
	output logic                     aw_ready_o,

	input  logic [DATA_W-1:0]        w_data_i,
	input  logic [DATA_W/BYTE_W-1:0] w_strb_i,
	input  logic                     w_valid_i,
	output logic                     w_ready_o,

	output resp_t                    b_resp_o,
	output logic                     b_valid_o,
	input  logic                     b_ready_i
);

	// single slave, channels go straight through to the controller
	axi_sram_ctrl #(
		.ADDR_W     (ADDR_W),
		.DATA_W     (DATA_W),
		.DEPTH_LOG2 (DEPTH_LOG2)
	) u_ctrl (
		.clk        (clk),
		.rst        (rst),
		.ar_addr_i  (ar_addr_i),
		.ar_valid_i (ar_valid_i),
		.ar_ready_o (ar_ready_o),
		.r_data_o   (r_data_o),
		.r_resp_o   (r_resp_o),
		.r_valid_o  (r_valid_o),
		.r_ready_i  (r_ready_i),
		.aw_addr_i  (aw_addr_i),
		.aw_valid_i (aw_valid_i),
		.aw_ready_o (aw_ready_o),
		.w_data_i   (w_data_i),
		.w_strb_i   (w_strb_i),
		.w_valid_i  (w_valid_i),
		.w_ready_o  (w_ready_o),
		.b_resp_o   (b_resp_o),
		.b_valid_o  (b_valid_o),
		.b_ready_i  (b_ready_i)
	);

endmodule

// ==== testbench/axi_mem_assert.sv ====
`timescale 1ns/1ps

module axi_mem_assert
	import axi_mem_pkg::*;
#(
	parameter int ADDR_W     = 32,
	parameter int DATA_W     = 32,
	parameter int DEPTH_LOG2 = 8
) (
	input logic                     clk,
	input logic                     rst,
	input ctrl_state_t              state_i, // controller state, from the bind
	input logic [ADDR_W-1:0]        ar_addr_i,
	input logic                     ar_valid_i,
	input logic                     ar_ready_o,
	input logic [DATA_W-1:0]        r_data_o,
	input resp_t                    r_resp_o,
	input logic                     r_valid_o,
	input logic                     r_ready_i,
	input logic [ADDR_W-1:0]        aw_addr_i,
	input logic                     aw_valid_i,
	input logic                     aw_ready_o,
	input logic [DATA_W-1:0]        w_data_i,
	input logic [DATA_W/BYTE_W-1:0] w_strb_i,
	input logic                     w_valid_i,
	input logic                     w_ready_o,
	input resp_t                    b_resp_o,
	input logic                     b_valid_o,
	input logic                     b_ready_i
);

	localparam int LANES  = DATA_W / BYTE_W;
	localparam int OFFS_W = $clog2(LANES);
	localparam int WORDS  = 1 << DEPTH_LOG2;

	int fail_cnt = 0;

	logic [DATA_W-1:0] shadow [WORDS];
	logic [WORDS-1:0]  known; // word has seen a full-strobe write
	logic [DATA_W-1:0] exp_rdata;
	logic              exp_known;
	resp_t             exp_rresp;
	resp_t             exp_bresp;

	logic                  rd_hs;
	logic                  wr_hs;
	logic [DEPTH_LOG2-1:0] rd_idx;
	logic [DEPTH_LOG2-1:0] wr_idx;
	logic                  rd_oob;
	logic                  wr_oob;

	assign rd_hs  = ar_valid_i && ar_ready_o;
	assign wr_hs  = aw_valid_i && w_valid_i && aw_ready_o && w_ready_o && !ar_valid_i;
	assign rd_idx = ar_addr_i[OFFS_W +: DEPTH_LOG2];
	assign wr_idx = aw_addr_i[OFFS_W +: DEPTH_LOG2];
	assign rd_oob = |(ar_addr_i >> (OFFS_W + DEPTH_LOG2));
	assign wr_oob = |(aw_addr_i >> (OFFS_W + DEPTH_LOG2));

	always_ff @(posedge clk) begin
		if (rst) begin
			known <= '0;
		end else begin
			if (rd_hs) begin
				exp_rdata <= rd_oob ? '0 : shadow[rd_idx];
				exp_known <= rd_oob || known[rd_idx];
				exp_rresp <= rd_oob ? RESP_SLVERR : RESP_OKAY;
			end
			if (wr_hs) begin
				exp_bresp <= wr_oob ? RESP_SLVERR : RESP_OKAY;
				if (!wr_oob) begin
					for (int i = 0; i < LANES; i++) begin
						if (w_strb_i[i]) begin
							shadow[wr_idx][i*BYTE_W +: BYTE_W] <= w_data_i[i*BYTE_W +: BYTE_W];
						end
					end
					if (&w_strb_i) begin
						known[wr_idx] <= 1'b1;
					end
				end
			end
		end
	end

	// quiet through reset and the cycle after
	a_reset_quiet: assert property (@(posedge clk)
		$past(rst) |-> !(ar_ready_o || aw_ready_o || w_ready_o || r_valid_o || b_valid_o))
		else begin
			$error("ready or valid output high during reset");
			fail_cnt++;
		end

	a_ready_idle: assert property (@(posedge clk) disable iff (rst)
		!$past(rst) |-> (ar_ready_o == (state_i == ST_IDLE)) &&
			(aw_ready_o == ar_ready_o) && (w_ready_o == ar_ready_o))
		else begin
			$error("input readies do not follow the idle state");
			fail_cnt++;
		end

	// one cycle to response valid, and read wins a race
	a_rd_latency: assert property (@(posedge clk) disable iff (rst)
		rd_hs |=> r_valid_o && !b_valid_o)
		else begin
			$error("read response not valid one cycle after the request");
			fail_cnt++;
		end

	a_wr_latency: assert property (@(posedge clk) disable iff (rst)
		wr_hs |=> b_valid_o && !r_valid_o)
		else begin
			$error("write response not valid one cycle after the request");
			fail_cnt++;
		end

	a_r_hold: assert property (@(posedge clk) disable iff (rst)
		r_valid_o && !r_ready_i |=> r_valid_o && $stable(r_data_o) && $stable(r_resp_o))
		else begin
			$error("read response changed while stalled");
			fail_cnt++;
		end

	a_b_hold: assert property (@(posedge clk) disable iff (rst)
		b_valid_o && !b_ready_i |=> b_valid_o && $stable(b_resp_o))
		else begin
			$error("write response changed while stalled");
			fail_cnt++;
		end

	a_r_data: assert property (@(posedge clk) disable iff (rst)
		r_valid_o && exp_known |-> r_data_o == exp_rdata)
		else begin
			$error("MISMATCH r_data_o exp %h got %h", exp_rdata, r_data_o);
			fail_cnt++;
		end

	a_r_resp: assert property (@(posedge clk) disable iff (rst)
		r_valid_o |-> r_resp_o == exp_rresp)
		else begin
			$error("MISMATCH r_resp_o exp %h got %h", exp_rresp, r_resp_o);
			fail_cnt++;
		end

	a_b_resp: assert property (@(posedge clk) disable iff (rst)
		b_valid_o |-> b_resp_o == exp_bresp)
		else begin
			$error("MISMATCH b_resp_o exp %h got %h", exp_bresp, b_resp_o);
			fail_cnt++;
		end

endmodule

// ==== testbench/tb_axi_mem.sv ====
`timescale 1ns/1ps

module tb_axi_mem
	import axi_mem_pkg::*;
();

	localparam int ADDR_W     = 32;
	localparam int DATA_W     = 32;
	localparam int DEPTH_LOG2 = 8;
	localparam int LANES      = DATA_W / BYTE_W;
	localparam int TIMEOUT    = 64; // cycles allowed per wait
	localparam int WINDOW     = 16; // words touched by the traffic

	logic              clk;
	logic              rst;
	logic [ADDR_W-1:0] ar_addr_i;
	logic              ar_valid_i;
	logic              ar_ready_o;
	logic [DATA_W-1:0] r_data_o;
	resp_t             r_resp_o;
	logic              r_valid_o;
	logic              r_ready_i;
	logic [ADDR_W-1:0] aw_addr_i;
	logic              aw_valid_i;
	logic              aw_ready_o;
	logic [DATA_W-1:0] w_data_i;
	logic [LANES-1:0]  w_strb_i;
	logic              w_valid_i;
	logic              w_ready_o;
	resp_t             b_resp_o;
	logic              b_valid_o;
	logic              b_ready_i;

	logic [31:0] lcg_q;
	int          timeouts;
	int          assert_fails;

	always #2 clk = ~clk;

	axi_mem_top #(
		.ADDR_W     (ADDR_W),
		.DATA_W     (DATA_W),
		.DEPTH_LOG2 (DEPTH_LOG2)
	) dut (.*);

	bind axi_mem_top axi_mem_assert #(
		.ADDR_W     (ADDR_W),
		.DATA_W     (DATA_W),
		.DEPTH_LOG2 (DEPTH_LOG2)
	) u_assert (.state_i(u_ctrl.state_q), .*);

	function automatic logic [31:0] next_rand();
		lcg_q = lcg_q * 32'd1664525 + 32'd1013904223;
		return lcg_q;
	endfunction

	function automatic logic [ADDR_W-1:0] window_addr(logic [31:0] r);
		logic [ADDR_W-1:0] a;
		a      = '0;
		a[5:2] = r[27:24];
		a[1:0] = r[21:20]; // byte offset ignored by the slave
		return a;
	endfunction

	// same word as window_addr but with upper bits set
	function automatic logic [ADDR_W-1:0] outside_addr(logic [31:0] r);
		logic [ADDR_W-1:0] a;
		a = window_addr(r);
		a[ADDR_W-1:DEPTH_LOG2+2] = r[31:DEPTH_LOG2+2] | 1'b1;
		return a;
	endfunction

	task automatic wait_ar_accept();
		int n;
		n = 0;
		@(posedge clk);
		while (!ar_ready_o && n < TIMEOUT) begin
			@(posedge clk);
			n++;
		end
		if (!ar_ready_o) begin
			$display("timeout: read address was never accepted");
			timeouts++;
		end
		ar_valid_i <= 1'b0;
	endtask

	task automatic wait_w_accept();
		int n;
		n = 0;
		@(posedge clk);
		while (!(aw_ready_o && !ar_valid_i) && n < TIMEOUT) begin
			@(posedge clk);
			n++;
		end
		if (!(aw_ready_o && !ar_valid_i)) begin
			$display("timeout: write address and data were never accepted");
			timeouts++;
		end
		aw_valid_i <= 1'b0;
		w_valid_i  <= 1'b0;
	endtask

	task automatic take_rresp(int stall);
		int n;
		n = 0;
		r_ready_i <= (stall == 0);
		@(posedge clk);
		while (!(r_valid_o && r_ready_i) && n < TIMEOUT) begin
			n++;
			if (n >= stall) begin
				r_ready_i <= 1'b1;
			end
			@(posedge clk);
		end
		if (!(r_valid_o && r_ready_i)) begin
			$display("timeout: read response never completed");
			timeouts++;
		end
		r_ready_i <= 1'b0;
	endtask

	task automatic take_bresp(int stall);
		int n;
		n = 0;
		b_ready_i <= (stall == 0);
		@(posedge clk);
		while (!(b_valid_o && b_ready_i) && n < TIMEOUT) begin
			n++;
			if (n >= stall) begin
				b_ready_i <= 1'b1;
			end
			@(posedge clk);
		end
		if (!(b_valid_o && b_ready_i)) begin
			$display("timeout: write response never completed");
			timeouts++;
		end
		b_ready_i <= 1'b0;
	endtask

	task automatic post_read(logic [ADDR_W-1:0] a);
		ar_addr_i  <= a;
		ar_valid_i <= 1'b1;
	endtask

	task automatic post_write(logic [ADDR_W-1:0] a, logic [DATA_W-1:0] d, logic [LANES-1:0] s);
		aw_addr_i  <= a;
		aw_valid_i <= 1'b1;
		w_data_i   <= d;
		w_strb_i   <= s;
		w_valid_i  <= 1'b1;
	endtask

	initial begin
		logic [31:0] r;
		logic [31:0] ra;
		logic [31:0] rw;
		int          stall;
		clk        = 1'b0;
		rst        = 1'b1;
		ar_addr_i  = '0;
		ar_valid_i = 1'b0;
		r_ready_i  = 1'b0;
		aw_addr_i  = '0;
		aw_valid_i = 1'b0;
		w_data_i   = '0;
		w_strb_i   = '0;
		w_valid_i  = 1'b0;
		b_ready_i  = 1'b0;
		lcg_q      = 32'hde061c2e;
		timeouts   = 0;
		repeat (16) @(posedge clk);
		rst <= 1'b0;
		repeat (4) @(posedge clk);
		// every window word gets a known value first
		for (int i = 0; i < WINDOW; i++) begin
			post_write(ADDR_W'(i * 4), next_rand(), '1);
			wait_w_accept();
			take_bresp(i % 3);
		end
		for (int k = 0; k < 300; k++) begin
			r     = next_rand();
			ra    = next_rand();
			rw    = next_rand();
			stall = int'(r[27:25]);
			case (r[31:29])
				3'd0, 3'd1, 3'd2: begin
					post_write(window_addr(rw), next_rand(), r[LANES+15:16]);
					wait_w_accept();
					take_bresp(stall);
				end
				3'd3, 3'd4: begin
					post_read(window_addr(ra));
					wait_ar_accept();
					take_rresp(stall);
				end
				3'd5: begin
					post_write(outside_addr(rw), next_rand(), '1);
					wait_w_accept();
					take_bresp(stall);
				end
				3'd6: begin
					post_read(outside_addr(ra));
					wait_ar_accept();
					take_rresp(stall);
				end
				default: begin // read and write raised together
					post_read(window_addr(ra));
					post_write(window_addr(rw), next_rand(), r[LANES+15:16]);
					wait_ar_accept();
					take_rresp(stall);
					wait_w_accept();
					take_bresp(stall);
				end
			endcase
		end
		repeat (4) @(posedge clk);
		assert_fails = dut.u_assert.fail_cnt;
		$display("errors: %0d timeouts, %0d assertion failures", timeouts, assert_fails);
		if (timeouts == 0 && assert_fails == 0) begin
			$display("Simulation PASSED");
		end else begin
			$display("Simulation FAILED");
		end
		$finish;
	end

endmodule

// ==== sources.f ====
common/axi_mem_pkg.sv
axi_sram/sram_array.sv
axi_sram/axi_sram_ctrl.sv
verilog/axi_mem_top.sv
testbench/axi_mem_assert.sv
testbench/tb_axi_mem.sv

// ==== Makefile ====
VERILATOR ?= verilator
TOP       ?= tb_axi_mem
FILELIST  ?= sources.f
OBJ_DIR   ?= obj_dir
JOBS      ?= 0
VFLAGS    ?= --binary --timing --assert -j $(JOBS)
RUN_ARGS  ?= +verilator+error+limit+1000
PASS_MSG  ?= Simulation PASSED

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(OBJ_DIR) -o V$(TOP)

run: build
	@out="$$(./$(OBJ_DIR)/V$(TOP) $(RUN_ARGS) 2>&1)"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

lint:
	$(VERILATOR) --lint-only --timing --assert --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR)
